// File: src/rtab_cfg_pkg.sv
// Replay table sizing
`default_nettype none

package rtab_cfg_pkg;

    // Default number of table slots
    // Sets the top level default and every pointer width below it
    localparam int rtab_entries_c = 4;

    // Width of a cache line index
    localparam int nline_width_c = 12;

    // Cache line index carried by every request
    typedef logic [nline_width_c-1:0] nline_t;

endpackage

`default_nettype wire

// File: src/rtab_req_pkg.sv
// Replay table request types
`default_nettype none

package rtab_req_pkg;

    // Request opcode
    typedef enum logic [1:0] {
        OP_LOAD     = 2'd0,
        OP_STORE    = 2'd1,
        OP_PREFETCH = 2'd2
    } rtab_op_e;

    // Request held in a slot
    // The id is carried through untouched
    typedef struct packed {
        rtab_cfg_pkg::nline_t nline;
        rtab_op_e             op;
        logic [7:0]           id;
    } rtab_req_t;

    // Conditions still blocking a replay
    typedef struct packed {
        // Cleared by a refill of the same line
        logic refill_wait;
        // Cleared once the miss handler is ready
        logic mshr_wait;
    } rtab_deps_t;

endpackage

`default_nettype wire

// File: src/rtab_alloc.sv
// Replay table slot allocator
`default_nettype none
`timescale 1ns/1ps

module rtab_alloc #(
    parameter int NumEntries = 4,
    localparam int PtrWidth = (NumEntries > 1) ? $clog2(NumEntries) : 1
) (
    input  wire logic                  alloc_i,
    input  wire logic                  alloc_link_i,
    input  wire logic [NumEntries-1:0] free_i,
    input  wire logic [NumEntries-1:0] tail_match_i,
    output logic      [NumEntries-1:0] alloc_sel_o,
    output logic      [NumEntries-1:0] head_set_o,
    output logic      [NumEntries-1:0] link_sel_o,
    output logic      [PtrWidth-1:0]   new_ptr_o
);

    // Lowest free slot, one-hot
    logic [NumEntries-1:0] free_first;
    logic                  alloc_any;

    // Priority encoder over the free vector
    always_comb begin : free_enc_comb
        logic found;
        found      = 1'b0;
        free_first = '0;
        new_ptr_o  = '0;
        for (int i = 0; i < NumEntries; i++) begin
            if (free_i[i] && !found) begin
                free_first[i] = 1'b1;
                new_ptr_o     = PtrWidth'(i);
                found         = 1'b1;
            end
        end
    end

    // Both strobes fill a slot
    assign alloc_any = alloc_i | alloc_link_i;

    assign alloc_sel_o = free_first & {NumEntries{alloc_any}};

    // Only a fresh list gets a head
    // A linked request waits behind the rest of its list
    assign head_set_o = free_first & {NumEntries{alloc_i}};

    // Old tail of the matching list points at the new slot
    assign link_sel_o = tail_match_i & {NumEntries{alloc_link_i}};

endmodule

`default_nettype wire

// File: src/rtab_entry.sv
// Replay table slot
`default_nettype none
`timescale 1ns/1ps

module rtab_entry #(
    parameter int NumEntries = 4,
    parameter int Index = 0,
    localparam int PtrWidth = (NumEntries > 1) ? $clog2(NumEntries) : 1
) (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire logic                     alloc_sel_i,
    input  wire logic                     head_set_i,
    input  wire logic                     link_sel_i,
    input  wire logic [PtrWidth-1:0]      new_ptr_i,
    input  wire rtab_req_pkg::rtab_req_t  req_i,
    input  wire rtab_req_pkg::rtab_deps_t deps_i,
    input  wire rtab_cfg_pkg::nline_t     check_nline_i,
    input  wire logic                     refill_i,
    input  wire rtab_cfg_pkg::nline_t     refill_nline_i,
    input  wire logic                     miss_ready_i,
    input  wire logic                     try_sel_i,
    input  wire logic                     commit_i,
    input  wire logic [PtrWidth-1:0]      commit_ptr_i,
    input  wire logic                     rback_i,
    input  wire logic [PtrWidth-1:0]      rback_ptr_i,
    output logic                          valid_o,
    output logic                          ready_o,
    output logic                          tail_o,
    output logic                          tail_match_o,
    output logic                          check_hit_o,
    output logic      [PtrWidth-1:0]      next_o,
    output rtab_req_pkg::rtab_req_t       req_o
);
    import rtab_cfg_pkg::*;
    import rtab_req_pkg::*;

    localparam logic [PtrWidth-1:0] SelfPtr = PtrWidth'(Index);

    logic          valid_q;
    logic          head_q;
    logic          tail_q;
    logic [PtrWidth-1:0] next_q;
    rtab_deps_t    deps_q;
    rtab_req_t     req_q;
    nline_t        line;
    logic          commit_hit;
    logic          rback_hit;
    logic          refill_hit;

    assign line = req_q.nline;

    // Broadcast pointers aimed at this slot
    assign commit_hit = commit_i & (commit_ptr_i == SelfPtr);
    assign rback_hit  = rback_i & (rback_ptr_i == SelfPtr);
    assign refill_hit = refill_i & (refill_nline_i == line);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            head_q  <= 1'b0;
            tail_q  <= 1'b0;
            next_q  <= '0;
            deps_q  <= '0;
        end else begin
            // Slot lifetime runs from allocation to commit
            if (alloc_sel_i) begin
                valid_q <= 1'b1;
            end else if (commit_hit) begin
                valid_q <= 1'b0;
            end

            // Head drops while popped, comes back on rollback
            if (alloc_sel_i) begin
                head_q <= head_set_i;
            end else if (rback_hit) begin
                head_q <= 1'b1;
            end else if (try_sel_i || commit_hit) begin
                head_q <= 1'b0;
            end

            // Newest request of a list is always its tail
            if (alloc_sel_i) begin
                tail_q <= 1'b1;
            end else if (link_sel_i) begin
                tail_q <= 1'b0;
                next_q <= new_ptr_i;
            end

            // Fresh deps on alloc and rollback, else wakeups clear them
            if (alloc_sel_i || rback_hit) begin
                deps_q <= deps_i;
            end else begin
                if (refill_hit) deps_q.refill_wait <= 1'b0;
                if (miss_ready_i) deps_q.mshr_wait <= 1'b0;
            end
        end
    end

    // Request payload, rewritten when a rollback hands back new contents
    always_ff @(posedge clk_i) begin
        if (alloc_sel_i || rback_hit) begin
            req_q <= req_i;
        end
    end

    assign valid_o      = valid_q;
    assign ready_o      = valid_q & head_q & ~(|deps_q);
    assign tail_o       = tail_q;
    assign check_hit_o  = valid_q & (check_nline_i == line);
    assign tail_match_o = check_hit_o & tail_q;
    assign next_o       = next_q;
    assign req_o        = req_q;

endmodule

`default_nettype wire

// File: src/rtab_rr_arb.sv
// Round-robin arbiter
`default_nettype none
`timescale 1ns/1ps

module rtab_rr_arb #(
    parameter int NumEntries = 4,
    localparam int PtrWidth = (NumEntries > 1) ? $clog2(NumEntries) : 1
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic [NumEntries-1:0] req_i,
    input  wire logic                  advance_i,
    output logic      [NumEntries-1:0] gnt_o
);

    // Last granted position and the one chosen this cycle
    logic [PtrWidth-1:0] last_q;
    logic [PtrWidth-1:0] gnt_idx;

    // Scan starts one past the last grant and wraps around
    always_comb begin : arb_comb
        int   idx;
        logic found;
        found   = 1'b0;
        gnt_o   = '0;
        gnt_idx = last_q;
        for (int off = 1; off <= NumEntries; off++) begin
            idx = (int'(last_q) + off) % NumEntries;
            if (req_i[idx] && !found) begin
                gnt_o[idx] = 1'b1;
                gnt_idx    = idx[PtrWidth-1:0];
                found      = 1'b1;
            end
        end
    end

    // Reset to the top slot so slot 0 wins first
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= PtrWidth'(NumEntries - 1);
        end else if (advance_i && |req_i) begin
            last_q <= gnt_idx;
        end
    end

endmodule

`default_nettype wire

// File: src/rtab_pop.sv
// Replay pop sequencer
`default_nettype none
`timescale 1ns/1ps

module rtab_pop #(
    parameter int NumEntries = 4,
    localparam int PtrWidth = (NumEntries > 1) ? $clog2(NumEntries) : 1
) (
    input  wire logic                                     clk_i,
    input  wire logic                                     rst_ni,
    input  wire logic                    [NumEntries-1:0] ready_i,
    input  wire logic                    [NumEntries-1:0] tail_i,
    input  wire logic [NumEntries-1:0]   [PtrWidth-1:0]   next_i,
    input  wire rtab_req_pkg::rtab_req_t [NumEntries-1:0] req_i,
    input  wire logic                                     pop_try_i,
    input  wire logic                                     pop_rback_i,
    output logic                         [NumEntries-1:0] try_sel_o,
    output logic                                          pop_try_valid_o,
    output rtab_req_pkg::rtab_req_t                       pop_req_o,
    output logic                         [PtrWidth-1:0]   pop_ptr_o
);

    typedef enum logic [1:0] {
        HEAD,
        NEXT,
        NEXT_WAIT
    } rtab_pop_state_e;

    rtab_pop_state_e       state_q, state_d;
    // Index of the list member to offer after a head
    logic [PtrWidth-1:0]   next_q, next_d;
    logic [NumEntries-1:0] gnt;
    logic [NumEntries-1:0] next_sel;
    logic [NumEntries-1:0] sel;
    logic [PtrWidth-1:0]   head_ptr;
    logic                  head_take;

    // Pick among ready heads, move on only once one is taken
    rtab_rr_arb #(
        .NumEntries(NumEntries)
    ) u_arb (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (ready_i),
        .advance_i(head_take),
        .gnt_o    (gnt)
    );

    always_comb begin : head_enc_comb
        head_ptr = '0;
        for (int i = 0; i < NumEntries; i++) begin
            if (gnt[i]) head_ptr = PtrWidth'(i);
        end
    end

    always_comb begin : next_dec_comb
        for (int i = 0; i < NumEntries; i++) begin
            next_sel[i] = (next_q == PtrWidth'(i));
        end
    end

    // List members behind a head go out without waiting on their deps
    assign pop_try_valid_o = (state_q == HEAD) ? |ready_i : 1'b1;

    always_comb begin : fsm_comb
        state_d   = state_q;
        next_d    = next_q;
        head_take = 1'b0;
        sel       = '0;
        unique case (state_q)
            HEAD: begin
                // A rollback of the last list tail may land here
                sel = gnt;
                if (!pop_rback_i && pop_try_valid_o && pop_try_i) begin
                    head_take = 1'b1;
                    if (!tail_i[head_ptr]) begin
                        state_d = NEXT;
                        next_d  = next_i[head_ptr];
                    end
                end
            end
            NEXT: begin
                sel = next_sel;
                // Rolled-back head will restart the whole list later
                if (pop_rback_i) begin
                    state_d = HEAD;
                end else if (pop_try_i) begin
                    if (tail_i[next_q]) begin
                        state_d = HEAD;
                    end else begin
                        next_d = next_i[next_q];
                    end
                end else begin
                    state_d = NEXT_WAIT;
                end
            end
            NEXT_WAIT: begin
                // Hold this member until it is taken
                sel = next_sel;
                if (pop_try_i) begin
                    if (tail_i[next_q]) begin
                        state_d = HEAD;
                    end else begin
                        state_d = NEXT;
                        next_d  = next_i[next_q];
                    end
                end
            end
            default: begin
                state_d = HEAD;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= HEAD;
            next_q  <= '0;
        end else begin
            state_q <= state_d;
            next_q  <= next_d;
        end
    end

    // Taken slot drops its head flag until commit or rollback
    assign try_sel_o = sel & {NumEntries{pop_try_i}};

    assign pop_ptr_o = (state_q == HEAD) ? head_ptr : next_q;
    assign pop_req_o = req_i[pop_ptr_o];

endmodule

`default_nettype wire

// File: src/rtab_top.sv
// Replay table top level
`default_nettype none
`timescale 1ns/1ps

module rtab_top #(
    parameter int NumEntries = rtab_cfg_pkg::rtab_entries_c,
    localparam int PtrWidth = (NumEntries > 1) ? $clog2(NumEntries) : 1
) (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire logic                     check_i,
    input  wire rtab_cfg_pkg::nline_t     check_nline_i,
    input  wire logic                     alloc_i,
    input  wire logic                     alloc_link_i,
    input  wire rtab_req_pkg::rtab_req_t  alloc_req_i,
    input  wire rtab_req_pkg::rtab_deps_t alloc_deps_i,
    input  wire logic                     pop_try_i,
    input  wire logic                     pop_commit_i,
    input  wire logic                     pop_rback_i,
    input  wire logic [PtrWidth-1:0]      pop_commit_ptr_i,
    input  wire logic [PtrWidth-1:0]      pop_rback_ptr_i,
    input  wire logic                     refill_i,
    input  wire rtab_cfg_pkg::nline_t     refill_nline_i,
    input  wire logic                     miss_ready_i,
    output logic                          empty_o,
    output logic                          full_o,
    output logic                          check_hit_o,
    output logic                          pop_try_valid_o,
    output rtab_req_pkg::rtab_req_t       pop_req_o,
    output logic      [PtrWidth-1:0]      pop_ptr_o
);
    import rtab_req_pkg::*;

    // Per-slot status
    logic [NumEntries-1:0] valid;
    logic [NumEntries-1:0] ready;
    logic [NumEntries-1:0] tail;
    logic [NumEntries-1:0] tail_match;
    logic [NumEntries-1:0] hit;
    logic [NumEntries-1:0][PtrWidth-1:0] next;
    rtab_req_t [NumEntries-1:0] req;

    // Allocation and pop controls fanned out to the slots
    logic [NumEntries-1:0] alloc_sel;
    logic [NumEntries-1:0] head_set;
    logic [NumEntries-1:0] link_sel;
    logic [NumEntries-1:0] try_sel;
    logic [PtrWidth-1:0]   new_ptr;

    rtab_alloc #(
        .NumEntries(NumEntries)
    ) u_alloc (
        .alloc_i     (alloc_i),
        .alloc_link_i(alloc_link_i),
        .free_i      (~valid),
        .tail_match_i(tail_match & {NumEntries{check_i}}),
        .alloc_sel_o (alloc_sel),
        .head_set_o  (head_set),
        .link_sel_o  (link_sel),
        .new_ptr_o   (new_ptr)
    );

    for (genvar i = 0; i < NumEntries; i++) begin : gen_entry
        rtab_entry #(
            .NumEntries(NumEntries),
            .Index     (i)
        ) u_entry (
            .clk_i         (clk_i),
            .rst_ni        (rst_ni),
            .alloc_sel_i   (alloc_sel[i]),
            .head_set_i    (head_set[i]),
            .link_sel_i    (link_sel[i]),
            .new_ptr_i     (new_ptr),
            .req_i         (alloc_req_i),
            .deps_i        (alloc_deps_i),
            .check_nline_i (check_nline_i),
            .refill_i      (refill_i),
            .refill_nline_i(refill_nline_i),
            .miss_ready_i  (miss_ready_i),
            .try_sel_i     (try_sel[i]),
            .commit_i      (pop_commit_i),
            .commit_ptr_i  (pop_commit_ptr_i),
            .rback_i       (pop_rback_i),
            .rback_ptr_i   (pop_rback_ptr_i),
            .valid_o       (valid[i]),
            .ready_o       (ready[i]),
            .tail_o        (tail[i]),
            .tail_match_o  (tail_match[i]),
            .check_hit_o   (hit[i]),
            .next_o        (next[i]),
            .req_o         (req[i])
        );
    end

    rtab_pop #(
        .NumEntries(NumEntries)
    ) u_pop (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .ready_i        (ready),
        .tail_i         (tail),
        .next_i         (next),
        .req_i          (req),
        .pop_try_i      (pop_try_i),
        .pop_rback_i    (pop_rback_i),
        .try_sel_o      (try_sel),
        .pop_try_valid_o(pop_try_valid_o),
        .pop_req_o      (pop_req_o),
        .pop_ptr_o      (pop_ptr_o)
    );

    // Table-wide status
    assign empty_o     = ~(|valid);
    assign full_o      = &valid;
    assign check_hit_o = check_i & (|hit);

endmodule

`default_nettype wire

// File: sim/rtab_tb.sv
// Replay table testbench
`default_nettype none
`timescale 1ns/1ps

module rtab_tb;
    import rtab_cfg_pkg::*;
    import rtab_req_pkg::*;

    localparam int NumEntries = 4;
    localparam int PtrWidth = $clog2(NumEntries);
    // Cycle budget for each data line
    localparam int CyclesPerLine = 20;

    // One data line with command fields first and expected values last
    typedef struct packed {
        logic [11:0] nline;
        logic [1:0]  op;
        logic [7:0]  id;
        logic [1:0]  deps;
        logic [11:0] e0;
        logic [11:0] e1;
        logic [11:0] e2;
    } vec_t;

    logic                clk_i;
    logic                rst_ni;
    logic                check;
    nline_t              check_nline;
    logic                alloc;
    logic                alloc_link;
    rtab_req_t           alloc_req;
    rtab_deps_t          alloc_deps;
    logic                pop_try;
    logic                pop_commit;
    logic                pop_rback;
    logic [PtrWidth-1:0] pop_commit_ptr;
    logic [PtrWidth-1:0] pop_rback_ptr;
    logic                refill;
    nline_t              refill_nline;
    logic                miss_ready;
    logic                empty;
    logic                full;
    logic                check_hit;
    logic                pop_try_valid;
    rtab_req_t           pop_req;
    logic [PtrWidth-1:0] pop_ptr;

    // Parsed data file
    string cmd_q[$];
    vec_t  vec_q[$];

    // Slot contents expected from lowest free allocation
    logic      slot_used[NumEntries];
    rtab_req_t slot_req[NumEntries];

    int   cycle_cnt = 0;
    int   cycle_limit = 0;
    logic running = 1'b0;

    rtab_top #(
        .NumEntries(NumEntries)
    ) u_dut (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .check_i         (check),
        .check_nline_i   (check_nline),
        .alloc_i         (alloc),
        .alloc_link_i    (alloc_link),
        .alloc_req_i     (alloc_req),
        .alloc_deps_i    (alloc_deps),
        .pop_try_i       (pop_try),
        .pop_commit_i    (pop_commit),
        .pop_rback_i     (pop_rback),
        .pop_commit_ptr_i(pop_commit_ptr),
        .pop_rback_ptr_i (pop_rback_ptr),
        .refill_i        (refill),
        .refill_nline_i  (refill_nline),
        .miss_ready_i    (miss_ready),
        .empty_o         (empty),
        .full_o          (full),
        .check_hit_o     (check_hit),
        .pop_try_valid_o (pop_try_valid),
        .pop_req_o       (pop_req),
        .pop_ptr_o       (pop_ptr)
    );

    // 4 ns clock
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Run limit
    always @(posedge clk_i) begin
        if (running) begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt >= cycle_limit) begin
                $display("Timeout after %0d cycles, the replay sequence never finished",
                         cycle_cnt);
                $display("TEST RESULT: FAIL");
                $fatal(1);
            end
        end
    end

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    function automatic rtab_req_t make_req(input logic [11:0] nline, input logic [1:0] op,
                                           input logic [7:0] id);
        rtab_req_t r;
        r.nline = nline;
        r.op    = rtab_op_e'(op);
        r.id    = id;
        return r;
    endfunction

    // Lowest unused slot of the model
    function automatic int free_slot();
        for (int i = 0; i < NumEntries; i++) begin
            if (!slot_used[i]) return i;
        end
        return -1;
    endfunction

    // Model slot holding the given request
    function automatic int slot_of(input rtab_req_t r);
        for (int i = 0; i < NumEntries; i++) begin
            if (slot_used[i] && slot_req[i] == r) return i;
        end
        return -1;
    endfunction

    // All inputs quiet right after a rising edge
    task automatic drive_defaults();
        check          <= 1'b0;
        check_nline    <= '0;
        alloc          <= 1'b0;
        alloc_link     <= 1'b0;
        alloc_req      <= '0;
        alloc_deps     <= '0;
        pop_try        <= 1'b0;
        pop_commit     <= 1'b0;
        pop_rback      <= 1'b0;
        pop_commit_ptr <= '0;
        pop_rback_ptr  <= '0;
        refill         <= 1'b0;
        refill_nline   <= '0;
        miss_ready     <= 1'b0;
    endtask

    // Quiet cycle then status against e0 e1 e2
    task automatic idle_cycle(input vec_t v);
        @(posedge clk_i);
        drive_defaults();
        @(negedge clk_i);
        compare_value(empty, v.e0, "empty_o");
        compare_value(full, v.e1, "full_o");
        compare_value(pop_try_valid, v.e2, "pop_try_valid_o");
    endtask

    // New list or a link behind the tail of the same line
    task automatic allocate(input vec_t v, input logic link);
        rtab_req_t req;
        int        slot;
        req = make_req(v.nline, v.op, v.id);
        @(posedge clk_i);
        drive_defaults();
        alloc      <= ~link;
        alloc_link <= link;
        alloc_req  <= req;
        alloc_deps <= rtab_deps_t'(v.deps);
        if (link) begin
            check       <= 1'b1;
            check_nline <= v.nline;
        end
        @(negedge clk_i);
        // Allocation is only legal while the table has room
        compare_value(full, 1'b0, "full_o during allocation");
        if (link) begin
            compare_value(check_hit, 1'b1, "check_hit_o during link");
        end
        // The new request lands in the lowest free slot
        slot = free_slot();
        if (slot < 0) begin
            $display("Data file allocates into a table that is already full");
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
        slot_used[slot] = 1'b1;
        slot_req[slot]  = req;
    endtask

    task automatic refill_line(input vec_t v);
        @(posedge clk_i);
        drive_defaults();
        refill       <= 1'b1;
        refill_nline <= v.nline;
    endtask

    task automatic raise_miss_ready();
        @(posedge clk_i);
        drive_defaults();
        miss_ready <= 1'b1;
    endtask

    task automatic lookup_line(input vec_t v);
        @(posedge clk_i);
        drive_defaults();
        check       <= 1'b1;
        check_nline <= v.nline;
        @(negedge clk_i);
        compare_value(check_hit, v.e0, "check_hit_o");
    endtask

    // Wait for an offer and take it before the commit or rollback
    task automatic replay_entry(input vec_t v, input logic rollback);
        logic [PtrWidth-1:0] ptr;
        rtab_req_t           exp_req;
        int                  exp_slot;
        exp_req  = make_req(v.nline, v.op, v.id);
        exp_slot = slot_of(exp_req);
        @(posedge clk_i);
        drive_defaults();
        @(negedge clk_i);
        while (pop_try_valid !== 1'b1) begin
            @(posedge clk_i);
            drive_defaults();
            @(negedge clk_i);
        end
        @(posedge clk_i);
        drive_defaults();
        pop_try <= 1'b1;
        @(negedge clk_i);
        // Offer must hold while it waits to be taken
        compare_value(pop_try_valid, 1'b1, "pop_try_valid_o in try cycle");
        compare_value(pop_req, exp_req, "replayed request");
        compare_value(pop_ptr, exp_slot, "pop_ptr_o");
        ptr = pop_ptr;
        @(posedge clk_i);
        drive_defaults();
        if (rollback) begin
            pop_rback     <= 1'b1;
            pop_rback_ptr <= ptr;
            alloc_req     <= make_req(v.e0, v.e1[1:0], v.e2[7:0]);
            alloc_deps    <= rtab_deps_t'(v.deps);
            slot_req[exp_slot] = make_req(v.e0, v.e1[1:0], v.e2[7:0]);
        end else begin
            pop_commit     <= 1'b1;
            pop_commit_ptr <= ptr;
            slot_used[exp_slot] = 1'b0;
        end
    endtask

    initial begin : main
        int          fd;
        int          n;
        string       line;
        string       cmd;
        logic [31:0] f0, f1, f2, f3, f4, f5, f6;
        vec_t        v;
        rst_ni = 1'b0;
        drive_defaults();
        foreach (slot_used[i]) begin
            slot_used[i] = 1'b0;
        end
        fd = $fopen("sim/rtab_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the data file sim/rtab_testdata.txt");
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment lines start with a hash
            if (line.len() == 0 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%s %h %h %h %h %h %h %h", cmd, f0, f1, f2, f3, f4, f5, f6);
            if (n == 8) begin
                v.nline = f0[11:0];
                v.op    = f1[1:0];
                v.id    = f2[7:0];
                v.deps  = f3[1:0];
                v.e0    = f4[11:0];
                v.e1    = f5[11:0];
                v.e2    = f6[11:0];
                cmd_q.push_back(cmd);
                vec_q.push_back(v);
            end else if (n > 0) begin
                $display("Data file line has the wrong number of fields: %s", line);
                $display("TEST RESULT: FAIL");
                $fatal(1);
            end
        end
        $fclose(fd);
        cycle_limit = CyclesPerLine * cmd_q.size();
        running = 1'b1;

        // Reset for 3 cycles
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;

        foreach (cmd_q[i]) begin
            v = vec_q[i];
            case (cmd_q[i])
                "idle":         idle_cycle(v);
                "alloc":        allocate(v, 1'b0);
                "link":         allocate(v, 1'b1);
                "refill":       refill_line(v);
                "missready":    raise_miss_ready();
                "try-commit":   replay_entry(v, 1'b0);
                "try-rollback": replay_entry(v, 1'b1);
                "check":        lookup_line(v);
                default: begin
                    $display("Unknown command in data file: %s", cmd_q[i]);
                    $display("TEST RESULT: FAIL");
                    $fatal(1);
                end
            endcase
        end

        // Let a trailing commit settle
        @(posedge clk_i);
        drive_defaults();
        @(posedge clk_i);
        running = 1'b0;
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/rtab_testdata.txt
# cmd nline op id deps e0 e1 e2, all hex, deps is {refill_wait, mshr_wait}
# idle e0..e2 = empty full offered, check e0 = hit, try-rollback e0..e2 = new nline op id
idle 000 0 00 0 1 0 0
alloc 123 0 a1 0 0 0 0
idle 000 0 00 0 0 0 1
try-commit 123 0 a1 0 0 0 0
idle 000 0 00 0 1 0 0
alloc 010 1 b0 0 0 0 0
alloc 020 0 b1 0 0 0 0
alloc 030 2 b2 0 0 0 0
alloc 040 1 b3 0 0 0 0
idle 000 0 00 0 0 1 1
check 010 0 00 0 1 0 0
check 040 0 00 0 1 0 0
check 055 0 00 0 0 0 0
try-commit 020 0 b1 0 0 0 0
try-commit 030 2 b2 0 0 0 0
try-commit 040 1 b3 0 0 0 0
try-commit 010 1 b0 0 0 0 0
idle 000 0 00 0 1 0 0
alloc 200 0 c0 2 0 0 0
refill 300 0 00 0 0 0 0
idle 000 0 00 0 0 0 0
refill 200 0 00 0 0 0 0
idle 000 0 00 0 0 0 1
try-commit 200 0 c0 0 0 0 0
alloc 210 1 c1 1 0 0 0
idle 000 0 00 0 0 0 0
missready 000 0 00 0 0 0 0
idle 000 0 00 0 0 0 1
try-commit 210 1 c1 0 0 0 0
alloc 400 0 d0 0 0 0 0
link 400 1 d1 0 0 0 0
link 400 2 d2 0 0 0 0
idle 000 0 00 0 0 0 1
try-commit 400 0 d0 0 0 0 0
try-commit 400 1 d1 0 0 0 0
try-commit 400 2 d2 0 0 0 0
idle 000 0 00 0 1 0 0
alloc 500 0 e0 0 0 0 0
try-rollback 500 0 e0 0 501 1 e5
idle 000 0 00 0 0 0 1
check 501 0 00 0 1 0 0
check 500 0 00 0 0 0 0
try-commit 501 1 e5 0 0 0 0
idle 000 0 00 0 1 0 0

// File: project.f
src/rtab_cfg_pkg.sv
src/rtab_req_pkg.sv
src/rtab_alloc.sv
src/rtab_entry.sv
src/rtab_rr_arb.sv
src/rtab_pop.sv
src/rtab_top.sv
sim/rtab_tb.sv

// File: Bender.yml
package:
  name: rtab

sources:
  - files:
      - src/rtab_cfg_pkg.sv
      - src/rtab_req_pkg.sv
      - src/rtab_alloc.sv
      - src/rtab_entry.sv
      - src/rtab_rr_arb.sv
      - src/rtab_pop.sv
      - src/rtab_top.sv
  - target: test
    files:
      - sim/rtab_tb.sv
